/* include/numdisp_macros.svh */
// Number display build constants
`ifndef NUMDISP_MACROS_SVH
`define NUMDISP_MACROS_SVH

// ----------------------------------------
// Data widths
// ----------------------------------------

// Counter value, divider operands and digit words
`define NUMDISP_WIDTH 8

// ----------------------------------------
// Display layout
// ----------------------------------------

`define NUMDISP_DIGITS 3 // Digits shown on the board
`define NUMDISP_BASE 10  // Conversion radix, 2 to 16

// Bits needed to address one digit slot
`define NUMDISP_IDX_WIDTH ((`NUMDISP_DIGITS > 1) ? $clog2(`NUMDISP_DIGITS) : 1)

// ----------------------------------------
// Board inputs
// ----------------------------------------

`define NUMDISP_BUTTONS 2 // Increment and decrement keys

`endif

/* verilog/numdisp_pkg.sv */
// Number display shared types
`default_nettype none

`include "numdisp_macros.svh"

package numdisp_pkg;

  // Counter value, dividend, quotient and remainder
  typedef logic [`NUMDISP_WIDTH-1:0] value_t;

  // One hex digit code for the segment lookup
  typedef logic [3:0] digit_t;

  // Active low segment pattern
  // Bit 0 is the top bar, then clockwise, bit 6 is the middle bar
  typedef logic [6:0] segments_t;

  // ----------------------------------------
  // Divider work register
  // ----------------------------------------

  // Split view for the add or subtract step
  typedef struct packed {
    value_t partial_rem;   // Upper half
    value_t dividend_bits; // Lower half, shifted out one per step
  } div_work_s;

  // Same bits, seen flat for the shift
  typedef union packed {
    logic [2*`NUMDISP_WIDTH-1:0] flat;
    div_work_s                   parts;
  } div_work_u;

endpackage

`default_nettype wire

/* verilog/div_if.sv */
// Divider link
`timescale 1ns/1ps
`default_nettype none

interface div_if;

  logic                start;     // Held high until done is seen
  logic                done;      // High while start stays high
  numdisp_pkg::value_t dividend;  // Stable while start is high
  numdisp_pkg::value_t quotient;
  numdisp_pkg::value_t remainder; // Also read by the display staging

  // Conversion controller side
  modport ctrl (
    output start,
    output dividend,
    input  done,
    input  quotient,
    input  remainder
  );

  // Divider side
  modport unit (
    input  start,
    input  dividend,
    output done,
    output quotient,
    output remainder
  );

endinterface

`default_nettype wire

/* verilog/button_counter.sv */
// Push button up/down counter
`timescale 1ns/1ps
`default_nettype none

`include "numdisp_macros.svh"

module button_counter (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`NUMDISP_BUTTONS-1:0]  buttons_n, // Active low keys
  output numdisp_pkg::value_t          value
);

  localparam int BTN_INC = 0; // Key that counts up
  localparam int BTN_DEC = 1; // Key that counts down

  logic [`NUMDISP_BUTTONS-1:0] sync_q1; // First synchroniser stage
  logic [`NUMDISP_BUTTONS-1:0] sync_q2; // Second synchroniser stage
  logic [`NUMDISP_BUTTONS-1:0] late_q;  // Previous synchronised level
  logic [`NUMDISP_BUTTONS-1:0] press;   // One cycle per key press

  // ----------------------------------------
  // Synchronisers and press detection
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      sync_q1 <= '1; // Keys idle high
      sync_q2 <= '1;
      late_q  <= '1;
    end else begin
      sync_q1 <= buttons_n;
      sync_q2 <= sync_q1;
      late_q  <= sync_q2;
    end
  end

  // Falling edge of the synchronised level
  assign press = late_q & ~sync_q2;

  // ----------------------------------------
  // Counter
  // ----------------------------------------

  // Wraps both ways, increment wins on a tie
  always_ff @(posedge clk) begin
    if (reset)
      value <= '0;
    else if (press[BTN_INC])
      value <= value + 1'b1;
    else if (press[BTN_DEC])
      value <= value - 1'b1;
  end

endmodule

`default_nettype wire

/* verilog/conv_ctrl.sv */
// Base conversion sequencer
`timescale 1ns/1ps
`default_nettype none

`include "numdisp_macros.svh"

module conv_ctrl (
  input  logic                           clk,
  input  logic                           reset,
  input  numdisp_pkg::value_t            value,     // Live counter value
  div_if.ctrl                            div,
  output logic                           digit_we,  // Remainder is valid for slot digit_idx
  output logic [`NUMDISP_IDX_WIDTH-1:0]  digit_idx,
  output logic                           commit     // Frame complete
);

  localparam int IDXW = `NUMDISP_IDX_WIDTH;
  localparam logic [IDXW-1:0] LAST_IDX = IDXW'(`NUMDISP_DIGITS - 1);

  typedef enum logic [1:0] {
    S_LOAD,   // Snapshot the counter
    S_START,  // Raise start once done has fallen
    S_WAIT,   // Hold start until done
    S_COMMIT  // Hand the frame to the display
  } state_t;

  state_t              state;
  logic [IDXW-1:0]     idx;      // Digit being produced
  logic                start;
  numdisp_pkg::value_t dividend; // Snapshot, then successive quotients
  logic                capture;  // Results taken this cycle

  assign capture  = (state == S_WAIT) && div.done;
  assign digit_we = capture;  // Divider remainder goes straight to staging
  assign digit_idx = idx;
  assign commit   = (state == S_COMMIT);

  assign div.start    = start;
  assign div.dividend = dividend;

  // ----------------------------------------
  // State machine
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_LOAD;
      idx   <= '0;
      start <= 1'b0;
    end else begin
      case (state)
        S_LOAD: begin
          idx   <= '0; // Least significant digit first
          state <= S_START;
        end
        S_START: begin
          if (!div.done) begin // Previous handshake fully closed
            start <= 1'b1;
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (div.done) begin
            start <= 1'b0;
            if (idx == LAST_IDX) begin
              state <= S_COMMIT;
            end else begin
              idx   <= idx + 1'b1;
              state <= S_START;
            end
          end
        end
        S_COMMIT: state <= S_LOAD; // Restart straight away
        default:  state <= S_LOAD;
      endcase
    end
  end

  // Dividend only changes between divisions
  always_ff @(posedge clk) begin
    if (state == S_LOAD)
      dividend <= value;
    else if (capture)
      dividend <= div.quotient; // Next digit comes from the quotient
  end

endmodule

`default_nettype wire

/* verilog/seq_divider.sv */
// Non-restoring divider by the fixed base
`timescale 1ns/1ps
`default_nettype none

`include "numdisp_macros.svh"

module seq_divider (
  input  logic clk,
  input  logic reset,
  div_if.unit  div
);

  localparam int W     = `NUMDISP_WIDTH;
  localparam int CNT_W = $clog2(`NUMDISP_WIDTH + 1);
  localparam numdisp_pkg::value_t DIVISOR = numdisp_pkg::value_t'(`NUMDISP_BASE);

  numdisp_pkg::div_work_u work;      // Partial remainder over dividend bits
  numdisp_pkg::div_work_u shifted;   // Work word moved up one place
  numdisp_pkg::div_work_u next_work; // Work word after this step
  numdisp_pkg::value_t    rem_step;  // Remainder after add or subtract
  numdisp_pkg::value_t    quotient;
  logic [CNT_W-1:0]       count;     // Steps left, zero when idle
  logic                   done;
  logic                   load;      // Take a new dividend
  logic                   step;      // Run one iteration
  logic                   last_step;

  assign load      = div.start && (count == '0) && !done;
  assign step      = div.start && (count != '0);
  assign last_step = (count == CNT_W'(1));

  // ----------------------------------------
  // One iteration
  // ----------------------------------------

  always_comb begin
    shifted.flat = work.flat << 1;
    // Sign of the partial remainder picks the operation
    if (shifted.parts.partial_rem[W-1])
      rem_step = shifted.parts.partial_rem + DIVISOR;
    else
      rem_step = shifted.parts.partial_rem - DIVISOR;
    next_work.parts.dividend_bits = shifted.parts.dividend_bits;
    // Final step restores a negative remainder
    if (last_step && rem_step[W-1])
      next_work.parts.partial_rem = rem_step + DIVISOR;
    else
      next_work.parts.partial_rem = rem_step;
  end

  // ----------------------------------------
  // Sequencing
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      done  <= 1'b0;
    end else if (div.start) begin
      if (load) begin
        count <= CNT_W'(W); // One step per dividend bit
      end else if (step) begin
        count <= count - 1'b1;
        if (last_step)
          done <= 1'b1; // Stays up while start is held
      end
    end else begin
      done <= 1'b0; // Falls the edge after start drops
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      work.parts.partial_rem   <= '0;
      work.parts.dividend_bits <= div.dividend;
      quotient                 <= '0;
    end else if (step) begin
      work     <= next_work;
      quotient <= {quotient[W-2:0], ~rem_step[W-1]}; // Inverted sign is the next bit
    end
  end

  assign div.done      = done;
  assign div.quotient  = quotient;
  assign div.remainder = work.parts.partial_rem;

endmodule

`default_nettype wire

/* verilog/seg_display.sv */
// Digit frame and seven-segment output
`timescale 1ns/1ps
`default_nettype none

`include "numdisp_macros.svh"

module seg_display (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic                                          digit_we,
  input  logic [`NUMDISP_IDX_WIDTH-1:0]                 digit_idx,
  input  logic                                          commit,
  input  numdisp_pkg::value_t                           remainder,
  output numdisp_pkg::segments_t [`NUMDISP_DIGITS-1:0]  segments,
  output logic                                          frame_update
);

  localparam int IDXW = `NUMDISP_IDX_WIDTH;

  numdisp_pkg::digit_t staged [`NUMDISP_DIGITS]; // Frame being built
  numdisp_pkg::digit_t shown  [`NUMDISP_DIGITS]; // Frame on the display

  // Hex digit to lit segments, active high
  function automatic numdisp_pkg::segments_t hex_lut(input numdisp_pkg::digit_t d);
    case (d)                  // 6543210
      4'h0:    hex_lut = 7'b0111111;
      4'h1:    hex_lut = 7'b0000110;
      4'h2:    hex_lut = 7'b1011011;
      4'h3:    hex_lut = 7'b1001111;
      4'h4:    hex_lut = 7'b1100110;
      4'h5:    hex_lut = 7'b1101101;
      4'h6:    hex_lut = 7'b1111101;
      4'h7:    hex_lut = 7'b0000111;
      4'h8:    hex_lut = 7'b1111111;
      4'h9:    hex_lut = 7'b1101111;
      4'hA:    hex_lut = 7'b1110111;
      4'hB:    hex_lut = 7'b1111100;
      4'hC:    hex_lut = 7'b0111001;
      4'hD:    hex_lut = 7'b1011110;
      4'hE:    hex_lut = 7'b1111001;
      default: hex_lut = 7'b1110001; // F
    endcase
  endfunction

  // ----------------------------------------
  // Staging and commit
  // ----------------------------------------

  always_ff @(posedge clk) begin
    for (int i = 0; i < `NUMDISP_DIGITS; i++) begin
      if (digit_we && digit_idx == IDXW'(i))
        staged[i] <= remainder[3:0]; // Remainder is below the base
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_update <= 1'b0;
      for (int i = 0; i < `NUMDISP_DIGITS; i++)
        shown[i] <= '0; // Shows zeros until the first frame
    end else begin
      frame_update <= commit; // Same edge as the new digits
      if (commit)
        shown <= staged;
    end
  end

  // Board segments are active low
  for (genvar g = 0; g < `NUMDISP_DIGITS; g++) begin : gen_seg
    assign segments[g] = ~hex_lut(shown[g]);
  end

endmodule

`default_nettype wire

/* verilog/numdisp_top.sv */
// Push button number display
`timescale 1ns/1ps
`default_nettype none

`include "numdisp_macros.svh"

module numdisp_top (
  input  logic                                          clk,
  input  logic                                          reset,
  input  logic [`NUMDISP_BUTTONS-1:0]                   buttons_n,
  output numdisp_pkg::value_t                           count,
  output numdisp_pkg::segments_t [`NUMDISP_DIGITS-1:0]  segments,
  output logic                                          frame_update
);

  logic                          digit_we;
  logic [`NUMDISP_IDX_WIDTH-1:0] digit_idx;
  logic                          commit;

  div_if div_bus (); // Controller to divider handshake

  // Keys to counter value
  button_counter u_button_counter (
    .clk       (clk),
    .reset     (reset),
    .buttons_n (buttons_n),
    .value     (count)
  );

  // ----------------------------------------
  // Conversion loop
  // ----------------------------------------

  conv_ctrl u_conv_ctrl (
    .clk       (clk),
    .reset     (reset),
    .value     (count),
    .div       (div_bus.ctrl),
    .digit_we  (digit_we),
    .digit_idx (digit_idx),
    .commit    (commit)
  );

  seq_divider u_seq_divider (
    .clk   (clk),
    .reset (reset),
    .div   (div_bus.unit)
  );

  // Digits come straight off the divider remainder
  seg_display u_seg_display (
    .clk          (clk),
    .reset        (reset),
    .digit_we     (digit_we),
    .digit_idx    (digit_idx),
    .commit       (commit),
    .remainder    (div_bus.remainder),
    .segments     (segments),
    .frame_update (frame_update)
  );

endmodule

`default_nettype wire

/* verification/numdisp_assertions.sv */
// Divider handshake checks
`timescale 1ns/1ps
`default_nettype none

module numdisp_assertions (
  input logic clk,
  input logic reset,
  input logic start, // Divider request, held until done
  input logic done   // Divider result ready
);

  int fail_count = 0; // Failed assertions, summed at end of run

  // ----------------------------------------
  // Divider handshake
  // ----------------------------------------

  // done only comes up under a held start
  done_needs_start: assert property (@(posedge clk) disable iff (reset)
    $rose(done) |-> start)
    else begin
      fail_count = fail_count + 1;
      $error("divider done rose while start was low");
    end

  // done drops on the edge after start drops
  done_follows_start: assert property (@(posedge clk) disable iff (reset)
    (done && !start) |=> !done)
    else begin
      fail_count = fail_count + 1;
      $error("divider done stayed high after start fell");
    end

  // Request is held until answered
  start_held: assert property (@(posedge clk) disable iff (reset)
    (start && !done) |=> start)
    else begin
      fail_count = fail_count + 1;
      $error("start fell before done");
    end

  // New request only once the old one is closed
  start_after_idle: assert property (@(posedge clk) disable iff (reset)
    $rose(start) |-> !done)
    else begin
      fail_count = fail_count + 1;
      $error("start rose while done was still high");
    end

endmodule

// Divider end of the link
bind seq_divider numdisp_assertions div_checks (
  .clk   (clk),
  .reset (reset),
  .start (div.start),
  .done  (done)
);

// Controller end of the link
bind conv_ctrl numdisp_assertions ctrl_checks (
  .clk   (clk),
  .reset (reset),
  .start (start),
  .done  (div.done)
);

`default_nettype wire

/* verification/numdisp_tb.sv */
// Number display testbench
`timescale 1ns/1ps
`default_nettype none

`include "numdisp_macros.svh"

module numdisp_tb;

  localparam int CLK_PERIOD     = 20;
  localparam int DRIVE_DELAY    = 2;    // Inputs change this long after the edge
  localparam int RESET_CYCLES   = 5;
  localparam int SEED           = 23127;
  localparam int HOLD_CYCLES    = 4;    // Key held down
  localparam int RELEASE_CYCLES = 4;    // Key released
  localparam int PRESS_CYCLES   = HOLD_CYCLES + RELEASE_CYCLES;
  localparam int INC_PRESSES    = 12;
  localparam int DEC_PRESSES    = 3;
  localparam int RAND_PRESSES   = 64;
  localparam int NUM_PRESSES    = INC_PRESSES + DEC_PRESSES + 1 + RAND_PRESSES;
  localparam int FRAME_CYCLES   = `NUMDISP_DIGITS * (`NUMDISP_WIDTH + 4) + 4;
  localparam int FRAME_WAIT     = 2 * FRAME_CYCLES; // Bound on one frame_update wait
  localparam int COUNT_MOD      = 1 << `NUMDISP_WIDTH;
  localparam int WATCHDOG_CYCLES =
    NUM_PRESSES * PRESS_CYCLES + 10 * FRAME_CYCLES + 2 * RESET_CYCLES + 4;

  logic                                          clk;
  logic                                          reset;
  logic [`NUMDISP_BUTTONS-1:0]                   buttons_n;
  numdisp_pkg::value_t                           count;
  numdisp_pkg::segments_t [`NUMDISP_DIGITS-1:0]  segments;
  logic                                          frame_update;

  int model_count;  // Expected counter value
  int errors;
  int checks;
  int assert_fails;
  logic update_seen; // frame_update at the previous negedge

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  numdisp_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .buttons_n    (buttons_n),
    .count        (count),
    .segments     (segments),
    .frame_update (frame_update)
  );

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Lit bars of a hex digit from the top bar (bit 0) to the middle bar (bit 6)
  function automatic numdisp_pkg::segments_t lit_segments(input int digit);
    logic [6:0] bars [16];
    bars = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
             7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
    return bars[digit & 15];
  endfunction

  // Digit at position pos, least significant is 0
  function automatic int model_digit(input int value, input int pos);
    int v;
    v = value;
    repeat (pos) v = v / `NUMDISP_BASE;
    return v % `NUMDISP_BASE;
  endfunction

  // ----------------------------------------
  // Stimulus and checks
  // ----------------------------------------

  task automatic apply_reset();
    @(posedge clk);
    #DRIVE_DELAY;
    reset     = 1'b1;
    buttons_n = '1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset       = 1'b0;
    model_count = 0;
  endtask

  // Press and release once under the increment priority rule
  task automatic press_buttons(input logic inc, input logic dec);
    @(posedge clk);
    #DRIVE_DELAY;
    buttons_n[0] = ~inc; // Keys are active low
    buttons_n[1] = ~dec;
    repeat (HOLD_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    buttons_n = '1;
    repeat (RELEASE_CYCLES - 1) @(posedge clk);
    if (inc)
      model_count = (model_count + 1) % COUNT_MOD;
    else if (dec)
      model_count = (model_count + COUNT_MOD - 1) % COUNT_MOD;
  endtask

  task automatic check_count();
    @(negedge clk); // Away from the driving edge
    checks++;
    if (count !== numdisp_pkg::value_t'(model_count)) begin
      errors++;
      $display("error at %0t: count is %0d, expected %0d", $time, count, model_count);
    end
  endtask

  task automatic check_display();
    numdisp_pkg::segments_t expected;
    int i;
    for (i = 0; i < `NUMDISP_DIGITS; i++) begin
      expected = ~lit_segments(model_digit(model_count, i));
      checks++;
      if (segments[i] !== expected) begin
        errors++;
        $display("error at %0t: digit %0d shows %b, expected %b",
                 $time, i, segments[i], expected);
      end
    end
  endtask

  // Returns on the negedge where frame_update is high
  task automatic wait_frame();
    int n;
    n = 0;
    @(negedge clk);
    while (!frame_update && n < FRAME_WAIT) begin
      @(negedge clk);
      n++;
    end
    checks++;
    if (!frame_update) begin
      errors++;
      $display("No frame_update pulse within %0d cycles, at %0t", FRAME_WAIT, $time);
    end
  endtask

  // Each frame_update pulse lasts one cycle
  always @(negedge clk) begin
    if (frame_update) begin
      checks++;
      if (update_seen) begin
        errors++;
        $display("error at %0t: frame_update stayed high for a second cycle", $time);
      end
    end
    update_seen = frame_update;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    int unsigned pick;
    reset       = 1'b1;
    buttons_n   = '1;
    errors      = 0;
    checks      = 0;
    model_count = 0;
    update_seen = 1'b0;
    void'($urandom(SEED));
    apply_reset();
    check_count();   // Zero out of reset
    check_display(); // Zeros before any frame
    wait_frame();
    check_display();
    repeat (INC_PRESSES) begin // Counting up one by one
      press_buttons(1'b1, 1'b0);
      check_count();
    end
    apply_reset();
    repeat (DEC_PRESSES) begin // Down through zero to the top value
      press_buttons(1'b0, 1'b1);
      check_count();
    end
    wait_frame(); // First frame may hold an old snapshot
    wait_frame();
    check_display();
    press_buttons(1'b1, 1'b1); // Tie goes to increment
    check_count();
    repeat (RAND_PRESSES) begin
      pick = $urandom % 4; // Idle, up, down or both
      press_buttons(pick[0], pick[1]);
      check_count();
    end
    wait_frame();
    wait_frame();
    check_count();
    check_display();
    repeat (4) wait_frame(); // Frames keep coming with keys idle
    assert_fails = dut0.u_seq_divider.div_checks.fail_count
                 + dut0.u_conv_ctrl.ctrl_checks.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog sized from press count and frame length
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not complete within %0d cycles", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
verilog/numdisp_pkg.sv
verilog/div_if.sv
verilog/button_counter.sv
verilog/conv_ctrl.sv
verilog/seq_divider.sv
verilog/seg_display.sv
verilog/numdisp_top.sv
verification/numdisp_assertions.sv
verification/numdisp_tb.sv

/* Makefile */
# Verilator simulation of the number display

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = numdisp_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+1000
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
